// ==== Bender.yml ====
package:
  name: rvchk

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvchk_pkg.sv
      - logic/rvchk_decode.sv
      - logic/rvchk_execute.sv
      - logic/rvchk_compare.sv
      - logic/rvchk_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/rvchk_asserts.sv
      - dv/rvchk_tb.sv

// ==== dv/rvchk_asserts.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_asserts (
  input logic                      clk_i,
  input logic                      rstn_i,
  input logic                      retire_valid_i,
  input logic [`RVCHK_RADDR_W-1:0] track_sel_i,
  input logic                      chk_valid_o,
  input logic                      pc_err_o,
  input logic                      reg_err_o,
  input logic                      track_known_o,
  input logic [`RVCHK_XLEN-1:0]    track_data_o
);

  int unsigned fail_cnt = 0;

  //////////////////////////////////////////////////
  // Protocol properties of rvchk_top
  //////////////////////////////////////////////////

  // First edge out of reset sees cleared outputs
  a_quiet_reset: assert property (@(posedge clk_i) $rose(rstn_i) |->
    !chk_valid_o && !pc_err_o && !reg_err_o && !track_known_o && track_data_o == '0)
    else begin
      $error("outputs not cleared by reset");
      fail_cnt++;
    end

  // Error pulses ride on a check strobe
  a_err_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (pc_err_o || reg_err_o) |-> chk_valid_o)
    else begin
      $error("error pulse without chk_valid_o");
      fail_cnt++;
    end

  // Fixed latency
  a_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
    chk_valid_o == $past(retire_valid_i, `RVCHK_PIPE_DEPTH))
    else begin
      $error("chk_valid_o not retire_valid_i delayed by pipeline depth");
      fail_cnt++;
    end

  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (track_sel_i == '0) |-> track_data_o == '0)
    else begin
      $error("tracked x0 holds a nonzero value");
      fail_cnt++;
    end

endmodule

bind rvchk_top rvchk_asserts u_asserts (.*);

// ==== dv/rvchk_tb.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_tb
  import rvchk_pkg::*;
();

  localparam int PERIOD_NS  = 4;
  // Cycle budget for the branch sweep and its setup writes plus random, directed and idle
  localparam int N_BRANCH   = 6 * 5 * 5 * 2 + 6 * 5;
  localparam int N_RANDOM   = 400;
  localparam int N_DIRECTED = 200;
  localparam int RUN_CYCLES = N_BRANCH + N_RANDOM + N_DIRECTED + 50;
  localparam logic [4:0] TRK = 5'd5;

  logic                      clk_i;
  logic                      rstn_i;
  logic                      retire_valid_i;
  logic [`RVCHK_ILEN-1:0]    instr_i;
  logic [`RVCHK_XLEN-1:0]    pc_i;
  logic [`RVCHK_XLEN-1:0]    rs1_data_i;
  logic [`RVCHK_XLEN-1:0]    rs2_data_i;
  logic [`RVCHK_XLEN-1:0]    rd_wdata_i;
  logic [`RVCHK_XLEN-1:0]    next_pc_i;
  logic                      trap_i;
  logic [`RVCHK_RADDR_W-1:0] track_sel_i;
  logic                      chk_valid_o;
  logic [`RVCHK_XLEN-1:0]    pred_next_pc_o;
  logic                      pc_err_o;
  logic                      reg_err_o;
  logic                      track_known_o;
  logic [`RVCHK_XLEN-1:0]    track_data_o;

  // Reference model state in program order
  logic        m_known;
  logic [31:0] m_data;
  logic [31:0] cur_pc;
  // Expectations of the instruction being driven
  logic        nxt_pcerr;
  logic        nxt_regerr;
  logic [31:0] nxt_pred;
  // Expectation pipeline indexed by cycles since the retire edge
  logic [3:1]  exp_v;
  logic [3:1]  exp_pcerr;
  logic [3:1]  exp_regerr;
  logic [31:0] exp_pred [1:3];
  logic [2:1]  exp_known;
  logic [31:0] exp_data [1:2];

  br_cond_e    conds [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
  // Signed and unsigned corner values
  logic [31:0] edge_vals [5] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};

  rvchk_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////

  task automatic end_failed();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, sig, exp, got);
    end_failed();
  endtask

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_ALUR};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] cond, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, cond, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // Mostly random data with the tracked value mixed in so equal compares happen
  function automatic logic [31:0] pick_data();
    if ($urandom_range(0, 3) == 0) begin
      return m_data;
    end
    if ($urandom_range(0, 3) == 0) begin
      return edge_vals[$urandom_range(0, 4)];
    end
    return $urandom();
  endfunction

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  // Retire one instruction and update the model
  // bad_pc and bad_wd corrupt the reported CPU values
  task automatic issue(input logic [31:0] instr, input logic [31:0] rs1d,
                       input logic [31:0] rs2d, input logic bad_pc,
                       input logic bad_wd, input logic trap);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] wval;
    logic [31:0] npc;
    logic        a_trk;
    logic        b_trk;
    logic        is_br;
    logic        is_wr;
    logic        no_rd;
    logic        taken;
    logic        hit;
    logic        pc_chk;
    @(posedge clk_i);
    #1;
    opc   = instr[6:0];
    f7    = instr[31:25];
    f3    = instr[14:12];
    rd    = instr[11:7];
    imm_i = $signed(instr[31:20]);
    imm_b = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0});
    imm_j = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0});
    a_trk = m_known && (instr[19:15] == track_sel_i);
    b_trk = m_known && (instr[24:20] == track_sel_i);
    a     = a_trk ? m_data : rs1d;
    b     = b_trk ? m_data : rs2d;
    is_br = 1'b0;
    is_wr = 1'b0;
    no_rd = 1'b0;
    taken = 1'b0;
    // Jumps link pc + 4 and everything else falls through
    res   = cur_pc + 32'd4;
    npc   = cur_pc + 32'd4;
    case (opc)
      OP_ALUR: begin
        if (f3 == 3'b000 && f7 == 7'h20) begin
          is_wr = 1'b1;
          res   = a - b;
        end
        if (f3 == 3'b110 && f7 == 7'h00) begin
          is_wr = 1'b1;
          res   = a | b;
        end
      end
      OP_ALUI: begin
        is_wr = (f3 == 3'b000);
        res   = a + imm_i;
      end
      OP_BRANCH: begin
        no_rd = 1'b1;
        is_br = (f3 != 3'b010) && (f3 != 3'b011);
        case (f3)
          BR_BEQ:  taken = (a == b);
          BR_BNE:  taken = (a != b);
          BR_BLT:  taken = ($signed(a) < $signed(b));
          BR_BGE:  taken = ($signed(a) >= $signed(b));
          BR_BLTU: taken = (a < b);
          BR_BGEU: taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (is_br && taken) begin
          npc = cur_pc + imm_b;
        end
      end
      OP_JAL: begin
        is_wr = 1'b1;
        npc   = cur_pc + imm_j;
      end
      OP_JALR: begin
        if (f3 == 3'b000) begin
          is_wr = 1'b1;
          npc   = (a + imm_i) & ~32'd1;
        end
      end
      OP_STORE, OP_FENCE, OP_SYSTEM: no_rd = 1'b1;
      default: no_rd = 1'b0;
    endcase
    hit        = !trap && (rd == track_sel_i);
    wval       = (track_sel_i == 5'd0) ? 32'd0 : res;
    pc_chk     = (is_wr || is_br) && !trap && (!is_br || a_trk || b_trk);
    nxt_pcerr  = pc_chk && bad_pc;
    nxt_regerr = hit && is_wr && bad_wd;
    nxt_pred   = npc;
    if (hit && is_wr) begin
      m_data  = wval;
      m_known = 1'b1;
    end else if (hit && !no_rd) begin
      m_known = 1'b0;
    end
    retire_valid_i = 1'b1;
    instr_i        = instr;
    pc_i           = cur_pc;
    rs1_data_i     = rs1d;
    rs2_data_i     = rs2d;
    rd_wdata_i     = ((rd == 5'd0) ? 32'd0 : res) ^ (bad_wd ? 32'h100 : 32'h0);
    next_pc_i      = npc ^ (bad_pc ? 32'h10 : 32'h0);
    trap_i         = trap;
    cur_pc         = npc;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      retire_valid_i = 1'b0;
    end
  endtask

  task automatic apply_reset(input logic [4:0] sel);
    @(posedge clk_i);
    #1;
    rstn_i         = 1'b0;
    retire_valid_i = 1'b0;
    trap_i         = 1'b0;
    track_sel_i    = sel;
    m_known        = 1'b0;
    m_data         = 32'd0;
    repeat (8) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;
  endtask

  // Tracked reg = 0 - (0 - v) with rs2 never the tracked reg
  task automatic set_track(input logic [31:0] v);
    issue(r_type(7'h20, 5'd6, 5'd0, 3'b000, TRK), 32'd0, 32'd0 - v, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic random_stream(input int n);
    logic [4:0]  regs [4];
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] instr;
    regs = '{5'd0, TRK, 5'd6, 5'd7};
    repeat (n) begin
      rd  = regs[$urandom_range(0, 3)];
      rs1 = regs[$urandom_range(0, 3)];
      rs2 = regs[$urandom_range(0, 3)];
      case ($urandom_range(0, 5))
        0: instr = r_type(7'h20, rs2, rs1, 3'b000, rd);
        1: instr = r_type(7'h00, rs2, rs1, 3'b110, rd);
        2: instr = i_type(12'($urandom()), rs1, 3'b000, rd, OP_ALUI);
        3: instr = b_type(conds[$urandom_range(0, 5)], rs1, rs2, 13'($urandom() << 1));
        4: instr = j_type(rd, 21'($urandom() << 1));
        default: instr = i_type(12'($urandom()), rs1, 3'b000, rd, OP_JALR);
      endcase
      issue(instr, pick_data(), pick_data(), $urandom_range(0, 7) == 0,
            $urandom_range(0, 7) == 0, $urandom_range(0, 15) == 0);
    end
  endtask

  // Expected values follow the DUT latency
  always @(posedge clk_i) begin
    if (!rstn_i) begin
      exp_v      <= '0;
      exp_pcerr  <= '0;
      exp_regerr <= '0;
      exp_known  <= '0;
      exp_data   <= '{32'd0, 32'd0};
    end else begin
      exp_v      <= {exp_v[2:1], retire_valid_i};
      exp_pcerr  <= {exp_pcerr[2:1], nxt_pcerr};
      exp_regerr <= {exp_regerr[2:1], nxt_regerr};
      exp_pred   <= '{nxt_pred, exp_pred[1], exp_pred[2]};
      exp_known  <= {exp_known[1], m_known};
      exp_data   <= '{m_data, exp_data[1]};
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_chk_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
    chk_valid_o == exp_v[3])
    else report_mismatch("chk_valid_o", $sampled(exp_v[3]), $sampled(chk_valid_o));
  a_pc_err: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pc_err_o == (exp_v[3] && exp_pcerr[3]))
    else report_mismatch("pc_err_o", $sampled(exp_v[3] && exp_pcerr[3]),
                         $sampled(pc_err_o));
  a_reg_err: assert property (@(posedge clk_i) disable iff (!rstn_i)
    reg_err_o == (exp_v[3] && exp_regerr[3]))
    else report_mismatch("reg_err_o", $sampled(exp_v[3] && exp_regerr[3]),
                         $sampled(reg_err_o));
  a_pred_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
    chk_valid_o |-> pred_next_pc_o == exp_pred[3])
    else report_mismatch("pred_next_pc_o", $sampled(exp_pred[3]), $sampled(pred_next_pc_o));
  // Tracked state is visible one cycle after the execute edge
  a_track_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
    track_known_o == exp_known[2])
    else report_mismatch("track_known_o", $sampled(exp_known[2]), $sampled(track_known_o));
  a_track_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
    track_data_o == exp_data[2])
    else report_mismatch("track_data_o", $sampled(exp_data[2]), $sampled(track_data_o));

  always @(posedge clk_i) begin
    if (u_dut.u_asserts.fail_cnt != 0) begin
      $display("A bound protocol assertion on rvchk_top failed at %0t", $time);
      end_failed();
    end
  end

  initial begin
    #(RUN_CYCLES * PERIOD_NS);
    $display("Watchdog expired after %0d cycles, stimulus did not complete", RUN_CYCLES);
    end_failed();
  end

  initial begin
    void'($urandom(67));
    rstn_i         = 1'b0;
    retire_valid_i = 1'b0;
    instr_i        = '0;
    pc_i           = '0;
    rs1_data_i     = '0;
    rs2_data_i     = '0;
    rd_wdata_i     = '0;
    next_pc_i      = '0;
    trap_i         = 1'b0;
    track_sel_i    = TRK;
    nxt_pcerr      = 1'b0;
    nxt_regerr     = 1'b0;
    nxt_pred       = '0;
    cur_pc         = 32'h1000;
    apply_reset(TRK);
    idle(4);
    // ALU writes to x5 with some corrupted rd values
    issue(i_type(12'd100, 5'd0, 3'b000, TRK, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(i_type(12'hffd, TRK, 3'b000, TRK, OP_ALUI), 32'd7, 32'd0, 1'b0, 1'b1, 1'b0);
    issue(r_type(7'h20, 5'd6, TRK, 3'b000, TRK), 32'd0, $urandom(), 1'b0, 1'b0, 1'b0);
    issue(r_type(7'h00, 5'd7, TRK, 3'b110, TRK), 32'd0, $urandom(), 1'b0, 1'b1, 1'b0);
    issue(r_type(7'h20, TRK, 5'd6, 3'b000, TRK), $urandom(), 32'd0, 1'b0, 1'b0, 1'b0);
    issue(i_type(12'd1, TRK, 3'b000, 5'd6, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b1, 1'b0);
    repeat (3) issue(i_type(12'd1, TRK, 3'b000, TRK, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    // All conditions with the tracked reg as rs1 then as rs2
    for (int c = 0; c < 6; c++) begin
      for (int t = 0; t < 5; t++) begin
        set_track(edge_vals[t]);
        for (int o = 0; o < 5; o++) begin
          issue(b_type(conds[c], TRK, 5'd6, 13'h010), ~edge_vals[t], edge_vals[o],
                o == 1, 1'b0, 1'b0);
          issue(b_type(conds[c], 5'd6, TRK, 13'h1ff4), edge_vals[o], ~edge_vals[t],
                o == 3, 1'b0, 1'b0);
        end
      end
    end
    // Jumps linking into x5 and JALR through x5
    issue(j_type(TRK, 21'h40), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(j_type(TRK, 21'h1ffff0), 32'd0, 32'd0, 1'b1, 1'b0, 1'b0);
    set_track(32'h2003);
    // Odd target sum so bit 0 must be cleared
    issue(i_type(12'd6, TRK, 3'b000, 5'd1, OP_JALR), 32'hdead, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(i_type(12'hfff, TRK, 3'b000, TRK, OP_JALR), 32'd0, 32'd0, 1'b1, 1'b0, 1'b0);
    issue(i_type(12'd5, 5'd8, 3'b000, 5'd6, OP_JALR), $urandom(), 32'd0, 1'b1, 1'b0, 1'b0);
    issue(j_type(5'd6, 21'h8), 32'd0, 32'd0, 1'b0, 1'b1, 1'b0);
    // Traps plus a store with rd field x5 and an unmodelled LUI to x5
    set_track(32'h55);
    issue(i_type(12'd1, TRK, 3'b000, TRK, OP_ALUI), 32'd0, 32'd0, 1'b1, 1'b1, 1'b1);
    issue(b_type(BR_BEQ, TRK, 5'd6, 13'h8), 32'd0, 32'd0, 1'b1, 1'b0, 1'b1);
    issue({7'h0, 5'd6, 5'd7, 3'b010, TRK, OP_STORE}, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue({20'h12345, TRK, 7'b0110111}, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(b_type(BR_BEQ, TRK, 5'd6, 13'h8), 32'd0, 32'd0, 1'b1, 1'b0, 1'b0);
    issue(b_type(BR_BLTU, 5'd6, TRK, 13'h8), 32'd1, 32'd9, 1'b1, 1'b0, 1'b0);
    issue(i_type(12'd3, 5'd0, 3'b000, TRK, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    random_stream(300);
    idle(4);
    // Tracked x0 must stay zero
    apply_reset(5'd0);
    idle(2);
    issue(i_type(12'd55, 5'd0, 3'b000, 5'd0, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(i_type(12'd9, 5'd0, 3'b000, 5'd0, OP_ALUI), 32'd0, 32'd0, 1'b0, 1'b1, 1'b0);
    issue(r_type(7'h20, 5'd7, 5'd6, 3'b000, 5'd0), 32'd10, 32'd3, 1'b0, 1'b0, 1'b0);
    issue(j_type(5'd0, 21'h10), 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
    issue(b_type(BR_BNE, 5'd0, 5'd6, 13'h20), 32'd0, 32'd4, 1'b1, 1'b0, 1'b0);
    random_stream(100);
    idle(6);
    if (u_dut.u_asserts.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      end_failed();
    end
  end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/rvchk_pkg.sv
logic/rvchk_decode.sv
logic/rvchk_execute.sv
logic/rvchk_compare.sv
logic/rvchk_top.sv
dv/rvchk_asserts.sv
dv/rvchk_tb.sv

// ==== logic/rvchk_compare.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_compare (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   ex_valid_i,
  input  logic [`RVCHK_XLEN-1:0] ex_pred_pc_i,
  input  logic                   ex_pc_check_i,
  input  logic                   ex_reg_check_i,
  input  logic [`RVCHK_XLEN-1:0] ex_reg_pred_i,
  input  logic [`RVCHK_XLEN-1:0] ex_next_pc_i,
  input  logic [`RVCHK_XLEN-1:0] ex_rd_wdata_i,
  output logic                   chk_valid_o,
  output logic [`RVCHK_XLEN-1:0] pred_next_pc_o,
  output logic                   pc_err_o,
  output logic                   reg_err_o
);

  logic pc_mismatch;
  logic reg_mismatch;

  //////////////////////////////////////////////////
  // Prediction vs CPU report
  //////////////////////////////////////////////////

  // Only trusted predictions count
  assign pc_mismatch  = ex_pc_check_i && (ex_pred_pc_i != ex_next_pc_i);
  // Tracked write data vs reported rd value
  assign reg_mismatch = ex_reg_check_i && (ex_reg_pred_i != ex_rd_wdata_i);

  // One-cycle pulses aligned with chk_valid_o
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      chk_valid_o <= 1'b0;
      pc_err_o    <= 1'b0;
      reg_err_o   <= 1'b0;
    end else begin
      chk_valid_o <= ex_valid_i;
      pc_err_o    <= ex_valid_i && pc_mismatch;
      reg_err_o   <= ex_valid_i && reg_mismatch;
    end
  end

  // Predicted PC held until the next check
  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      pred_next_pc_o <= ex_pred_pc_i;
    end
  end

endmodule

// ==== logic/rvchk_consts.svh ====
`ifndef RVCHK_CONSTS_SVH
`define RVCHK_CONSTS_SVH

// Datapath and PC width
`define RVCHK_XLEN        32
`define RVCHK_ILEN        32
`define RVCHK_RADDR_W     5
// Sequential fetch step
`define RVCHK_PC_STEP     4
// Retire to check latency in cycles
`define RVCHK_PIPE_DEPTH  3

// funct3 / funct7 values of the supported ALU ops
`define RVCHK_F3_ADD_SUB  3'b000
`define RVCHK_F3_OR       3'b110
`define RVCHK_F3_ADDI     3'b000
`define RVCHK_F3_JALR     3'b000
`define RVCHK_F7_SUB      7'b0100000
`define RVCHK_F7_BASE     7'b0000000

`endif

// ==== logic/rvchk_decode.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_decode
  import rvchk_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      retire_valid_i,
  input  logic [`RVCHK_ILEN-1:0]    instr_i,
  input  logic [`RVCHK_XLEN-1:0]    pc_i,
  input  logic [`RVCHK_XLEN-1:0]    rs1_data_i,
  input  logic [`RVCHK_XLEN-1:0]    rs2_data_i,
  input  logic [`RVCHK_XLEN-1:0]    rd_wdata_i,
  input  logic [`RVCHK_XLEN-1:0]    next_pc_i,
  input  logic                      trap_i,
  output logic                      dec_valid_o,
  output instr_class_e              dec_class_o,
  output br_cond_e                  dec_cond_o,
  output logic [`RVCHK_RADDR_W-1:0] dec_rd_o,
  output logic [`RVCHK_RADDR_W-1:0] dec_rs1_o,
  output logic [`RVCHK_RADDR_W-1:0] dec_rs2_o,
  output logic [`RVCHK_XLEN-1:0]    dec_imm_o,
  output logic [`RVCHK_XLEN-1:0]    dec_pc_o,
  output logic [`RVCHK_XLEN-1:0]    dec_rs1_data_o,
  output logic [`RVCHK_XLEN-1:0]    dec_rs2_data_o,
  output logic [`RVCHK_XLEN-1:0]    dec_rd_wdata_o,
  output logic [`RVCHK_XLEN-1:0]    dec_next_pc_o,
  output logic                      dec_trap_o
);

  logic [6:0]             funct7;
  logic [2:0]             funct3;
  logic [`RVCHK_XLEN-1:0] imm_i;
  logic [`RVCHK_XLEN-1:0] imm_b;
  logic [`RVCHK_XLEN-1:0] imm_j;
  logic [`RVCHK_XLEN-1:0] imm_d;
  instr_class_e           cls_d;

  assign funct7 = instr_i[31:25];
  assign funct3 = instr_i[14:12];

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  // I-type, ADDI and JALR
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  // B-type, bit 0 always zero
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  // J-type
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////

  always_comb begin
    // Anything unknown is assumed to write rd
    cls_d = CLS_OTHER_WR;
    imm_d = imm_i;
    case (opcode_e'(instr_i[6:0]))
      OP_ALUR: begin
        if (funct3 == `RVCHK_F3_ADD_SUB && funct7 == `RVCHK_F7_SUB) begin
          cls_d = CLS_SUB;
        end else if (funct3 == `RVCHK_F3_OR && funct7 == `RVCHK_F7_BASE) begin
          cls_d = CLS_OR;
        end
      end
      OP_ALUI: begin
        if (funct3 == `RVCHK_F3_ADDI) begin
          cls_d = CLS_ADDI;
        end
      end
      OP_BRANCH: begin
        imm_d = imm_b;
        // funct3 010/011 are reserved, no rd either way
        if (funct3 inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU}) begin
          cls_d = CLS_BRANCH;
        end else begin
          cls_d = CLS_NONE;
        end
      end
      OP_JAL: begin
        cls_d = CLS_JAL;
        imm_d = imm_j;
      end
      OP_JALR: begin
        if (funct3 == `RVCHK_F3_JALR) begin
          cls_d = CLS_JALR;
        end
      end
      OP_STORE, OP_FENCE, OP_SYSTEM: begin
        cls_d = CLS_NONE;
      end
      default: begin
        cls_d = CLS_OTHER_WR;
      end
    endcase
  end

  // Stage valid
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= retire_valid_i;
    end
  end

  // Decoded fields plus carried CPU report
  always_ff @(posedge clk_i) begin
    if (retire_valid_i) begin
      dec_class_o    <= cls_d;
      dec_cond_o     <= br_cond_e'(funct3);
      dec_rd_o       <= instr_i[11:7];
      dec_rs1_o      <= instr_i[19:15];
      dec_rs2_o      <= instr_i[24:20];
      dec_imm_o      <= imm_d;
      dec_pc_o       <= pc_i;
      dec_rs1_data_o <= rs1_data_i;
      dec_rs2_data_o <= rs2_data_i;
      dec_rd_wdata_o <= rd_wdata_i;
      dec_next_pc_o  <= next_pc_i;
      dec_trap_o     <= trap_i;
    end
  end

endmodule

// ==== logic/rvchk_execute.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_execute
  import rvchk_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic [`RVCHK_RADDR_W-1:0] track_sel_i,
  input  logic                      dec_valid_i,
  input  instr_class_e              dec_class_i,
  input  br_cond_e                  dec_cond_i,
  input  logic [`RVCHK_RADDR_W-1:0] dec_rd_i,
  input  logic [`RVCHK_RADDR_W-1:0] dec_rs1_i,
  input  logic [`RVCHK_RADDR_W-1:0] dec_rs2_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_imm_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_pc_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_rs1_data_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_rs2_data_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_rd_wdata_i,
  input  logic [`RVCHK_XLEN-1:0]    dec_next_pc_i,
  input  logic                      dec_trap_i,
  output logic                      ex_valid_o,
  output logic [`RVCHK_XLEN-1:0]    ex_pred_pc_o,
  output logic                      ex_pc_check_o,
  output logic                      ex_reg_check_o,
  output logic [`RVCHK_XLEN-1:0]    ex_reg_pred_o,
  output logic [`RVCHK_XLEN-1:0]    ex_next_pc_o,
  output logic [`RVCHK_XLEN-1:0]    ex_rd_wdata_o,
  output logic                      track_known_o,
  output logic [`RVCHK_XLEN-1:0]    track_data_o
);

  logic [`RVCHK_XLEN-1:0] track_data_q;
  logic                   track_known_q;
  logic                   rs1_trk;
  logic                   rs2_trk;
  logic [`RVCHK_XLEN-1:0] op_a;
  logic [`RVCHK_XLEN-1:0] op_b;
  logic [`RVCHK_XLEN-1:0] pc_seq;
  logic [`RVCHK_XLEN-1:0] pc_rel;
  logic [`RVCHK_XLEN-1:0] jalr_sum;
  logic [`RVCHK_XLEN-1:0] result;
  logic [`RVCHK_XLEN-1:0] wr_value;
  logic [`RVCHK_XLEN-1:0] pred_pc;
  logic                   taken;
  logic                   supported;
  logic                   supported_wr;
  logic                   hits_track;
  logic                   pc_check;

  //////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////

  // Known tracked value overrides the CPU operand
  assign rs1_trk = track_known_q && (dec_rs1_i == track_sel_i);
  assign rs2_trk = track_known_q && (dec_rs2_i == track_sel_i);
  assign op_a    = rs1_trk ? track_data_q : dec_rs1_data_i;
  assign op_b    = rs2_trk ? track_data_q : dec_rs2_data_i;

  assign pc_seq   = dec_pc_i + `RVCHK_PC_STEP;
  assign pc_rel   = dec_pc_i + dec_imm_i;
  assign jalr_sum = op_a + dec_imm_i;

  // Branch resolution
  always_comb begin
    case (dec_cond_i)
      BR_BEQ:  taken = (op_a == op_b);
      BR_BNE:  taken = (op_a != op_b);
      BR_BLT:  taken = ($signed(op_a) < $signed(op_b));
      BR_BGE:  taken = ($signed(op_a) >= $signed(op_b));
      BR_BLTU: taken = (op_a < op_b);
      BR_BGEU: taken = (op_a >= op_b);
      default: taken = 1'b0;
    endcase
  end

  // Write-back result and next PC
  always_comb begin
    result  = '0;
    pred_pc = pc_seq;
    case (dec_class_i)
      CLS_SUB:    result = op_a - op_b;
      CLS_OR:     result = op_a | op_b;
      CLS_ADDI:   result = op_a + dec_imm_i;
      CLS_BRANCH: pred_pc = taken ? pc_rel : pc_seq;
      CLS_JAL: begin
        result  = pc_seq;
        pred_pc = pc_rel;
      end
      CLS_JALR: begin
        result  = pc_seq;
        // Target LSB dropped
        pred_pc = {jalr_sum[`RVCHK_XLEN-1:1], 1'b0};
      end
      default: begin
        result  = '0;
        pred_pc = pc_seq;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Check qualifiers
  //////////////////////////////////////////////////

  assign supported    = !(dec_class_i inside {CLS_OTHER_WR, CLS_NONE});
  assign supported_wr = dec_class_i inside {CLS_SUB, CLS_OR, CLS_ADDI, CLS_JAL, CLS_JALR};
  assign hits_track   = dec_valid_i && !dec_trap_i && (dec_rd_i == track_sel_i);
  // x0 stays zero whatever the result
  assign wr_value     = (track_sel_i == '0) ? '0 : result;
  // Branch outcome only trusted on a known tracked operand
  assign pc_check     = supported && !dec_trap_i &&
                        ((dec_class_i != CLS_BRANCH) || rs1_trk || rs2_trk);

  // Tracked register, visible to the very next instruction
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ex_valid_o    <= 1'b0;
      track_known_q <= 1'b0;
      track_data_q  <= '0;
    end else begin
      ex_valid_o <= dec_valid_i;
      if (hits_track && supported_wr) begin
        track_data_q  <= wr_value;
        track_known_q <= 1'b1;
      end else if (hits_track && dec_class_i == CLS_OTHER_WR) begin
        // Value lost to an unmodelled write
        track_known_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      ex_pred_pc_o   <= pred_pc;
      ex_pc_check_o  <= pc_check;
      ex_reg_check_o <= hits_track && supported_wr;
      ex_reg_pred_o  <= wr_value;
      ex_next_pc_o   <= dec_next_pc_i;
      ex_rd_wdata_o  <= dec_rd_wdata_i;
    end
  end

  assign track_known_o = track_known_q;
  assign track_data_o  = track_data_q;

endmodule

// ==== logic/rvchk_pkg.sv ====
package rvchk_pkg;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  // STORE, FENCE and SYSTEM only matter for the no-rd class
  typedef enum logic [6:0] {
    OP_ALUR   = 7'b0110011,
    OP_ALUI   = 7'b0010011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_STORE  = 7'b0100011,
    OP_FENCE  = 7'b0001111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Branch funct3 encodings
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

  // Decoded class
  typedef enum logic [2:0] {
    CLS_SUB,
    CLS_OR,
    CLS_ADDI,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_OTHER_WR,  // unsupported, writes rd
    CLS_NONE       // unsupported, no rd
  } instr_class_e;

endpackage

// ==== logic/rvchk_top.sv ====
`timescale 1ns/1ps
`include "rvchk_consts.svh"

module rvchk_top
  import rvchk_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      retire_valid_i,
  input  logic [`RVCHK_ILEN-1:0]    instr_i,
  input  logic [`RVCHK_XLEN-1:0]    pc_i,
  input  logic [`RVCHK_XLEN-1:0]    rs1_data_i,
  input  logic [`RVCHK_XLEN-1:0]    rs2_data_i,
  input  logic [`RVCHK_XLEN-1:0]    rd_wdata_i,
  input  logic [`RVCHK_XLEN-1:0]    next_pc_i,
  input  logic                      trap_i,
  input  logic [`RVCHK_RADDR_W-1:0] track_sel_i,
  output logic                      chk_valid_o,
  output logic [`RVCHK_XLEN-1:0]    pred_next_pc_o,
  output logic                      pc_err_o,
  output logic                      reg_err_o,
  output logic                      track_known_o,
  output logic [`RVCHK_XLEN-1:0]    track_data_o
);

  //////////////////////////////////////////////////
  // Decode to execute
  //////////////////////////////////////////////////
  logic                      dec_valid;
  instr_class_e              dec_class;
  br_cond_e                  dec_cond;
  logic [`RVCHK_RADDR_W-1:0] dec_rd;
  logic [`RVCHK_RADDR_W-1:0] dec_rs1;
  logic [`RVCHK_RADDR_W-1:0] dec_rs2;
  logic [`RVCHK_XLEN-1:0]    dec_imm;
  logic [`RVCHK_XLEN-1:0]    dec_pc;
  logic [`RVCHK_XLEN-1:0]    dec_rs1_data;
  logic [`RVCHK_XLEN-1:0]    dec_rs2_data;
  logic [`RVCHK_XLEN-1:0]    dec_rd_wdata;
  logic [`RVCHK_XLEN-1:0]    dec_next_pc;
  logic                      dec_trap;

  //////////////////////////////////////////////////
  // Execute to compare
  //////////////////////////////////////////////////
  logic                      ex_valid;
  logic [`RVCHK_XLEN-1:0]    ex_pred_pc;
  logic                      ex_pc_check;
  logic                      ex_reg_check;
  logic [`RVCHK_XLEN-1:0]    ex_reg_pred;
  logic [`RVCHK_XLEN-1:0]    ex_next_pc;
  logic [`RVCHK_XLEN-1:0]    ex_rd_wdata;

  // Stage 1
  rvchk_decode u_decode (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .retire_valid_i (retire_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .rd_wdata_i     (rd_wdata_i),
    .next_pc_i      (next_pc_i),
    .trap_i         (trap_i),
    .dec_valid_o    (dec_valid),
    .dec_class_o    (dec_class),
    .dec_cond_o     (dec_cond),
    .dec_rd_o       (dec_rd),
    .dec_rs1_o      (dec_rs1),
    .dec_rs2_o      (dec_rs2),
    .dec_imm_o      (dec_imm),
    .dec_pc_o       (dec_pc),
    .dec_rs1_data_o (dec_rs1_data),
    .dec_rs2_data_o (dec_rs2_data),
    .dec_rd_wdata_o (dec_rd_wdata),
    .dec_next_pc_o  (dec_next_pc),
    .dec_trap_o     (dec_trap)
  );

  // Stage 2, owns the tracked register
  rvchk_execute u_execute (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .track_sel_i    (track_sel_i),
    .dec_valid_i    (dec_valid),
    .dec_class_i    (dec_class),
    .dec_cond_i     (dec_cond),
    .dec_rd_i       (dec_rd),
    .dec_rs1_i      (dec_rs1),
    .dec_rs2_i      (dec_rs2),
    .dec_imm_i      (dec_imm),
    .dec_pc_i       (dec_pc),
    .dec_rs1_data_i (dec_rs1_data),
    .dec_rs2_data_i (dec_rs2_data),
    .dec_rd_wdata_i (dec_rd_wdata),
    .dec_next_pc_i  (dec_next_pc),
    .dec_trap_i     (dec_trap),
    .ex_valid_o     (ex_valid),
    .ex_pred_pc_o   (ex_pred_pc),
    .ex_pc_check_o  (ex_pc_check),
    .ex_reg_check_o (ex_reg_check),
    .ex_reg_pred_o  (ex_reg_pred),
    .ex_next_pc_o   (ex_next_pc),
    .ex_rd_wdata_o  (ex_rd_wdata),
    .track_known_o  (track_known_o),
    .track_data_o   (track_data_o)
  );

  // Stage 3
  rvchk_compare u_compare (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .ex_valid_i     (ex_valid),
    .ex_pred_pc_i   (ex_pred_pc),
    .ex_pc_check_i  (ex_pc_check),
    .ex_reg_check_i (ex_reg_check),
    .ex_reg_pred_i  (ex_reg_pred),
    .ex_next_pc_i   (ex_next_pc),
    .ex_rd_wdata_i  (ex_rd_wdata),
    .chk_valid_o    (chk_valid_o),
    .pred_next_pc_o (pred_next_pc_o),
    .pc_err_o       (pc_err_o),
    .reg_err_o      (reg_err_o)
  );

endmodule
